//--- source/pakout_pkg.sv
package pakout_pkg;

	// Packet field widths
	localparam int ASZ = 6;
	localparam int DSZ = 8;
	localparam int RSZ = 4;

	// Address this endpoint stamps on every packet and expects back
	localparam logic [ASZ-1:0] DBG_SRC_ADDR = 3;

	// dbg_case values below this one show the source status
	localparam int DBG_MAX_SRC_CASE = 4;

	// Bits covered by the redundancy code padded to whole slices
	localparam int RED_FSZ = 2 * ASZ + DSZ;
	localparam int RED_NSL = (RED_FSZ + RSZ - 1) / RSZ;

	// XOR of all RSZ-bit slices of src, dst and dat
	function automatic logic [RSZ-1:0] calc_redun(
		input logic [ASZ-1:0] src,
		input logic [ASZ-1:0] dst,
		input logic [DSZ-1:0] dat
	);
		logic [RED_NSL*RSZ-1:0] all_bits;
		logic [RSZ-1:0] acc;
		all_bits = '0;
		all_bits[RED_FSZ-1:0] = {src, dst, dat};
		acc = '0;
		for (int i = 0; i < RED_NSL; i++) begin
			acc = acc ^ all_bits[i*RSZ +: RSZ];
		end
		return acc;
	endfunction

endpackage

//--- source/pak_chnl_if.sv
`timescale 1ns/10ps

interface pak_chnl_if;
	import pakout_pkg::*;

	// Four-phase request/acknowledge handshake
	logic req;
	logic ack;

	// Packet fields that stay valid while req is high
	logic [ASZ-1:0] src;
	logic [ASZ-1:0] dst;
	logic [DSZ-1:0] dat;
	logic [RSZ-1:0] red;

	modport sender (
		output req, src, dst, dat, red,
		input  ack
	);

	modport receiver (
		input  req, src, dst, dat, red,
		output ack
	);

endinterface

//--- source/pakout_src.sv
`timescale 1ns/10ps

module pakout_src #(
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 4
) (
	input  logic                       i_clk,
	input  logic                       reset,
	input  logic                       enable,
	pak_chnl_if.sender                 ch,
	output logic [3:0]                 sent_cnt,
	output logic [pakout_pkg::ASZ-1:0] last_dst
);
	import pakout_pkg::*;

	localparam logic [ASZ-1:0] MIN_A = ASZ'(MIN_ADDR);
	localparam logic [ASZ-1:0] MAX_A = ASZ'(MAX_ADDR);

	logic           busy;
	logic           req;
	logic [ASZ-1:0] nxt_dst;
	logic [DSZ-1:0] dat_cnt;
	logic [ASZ-1:0] dst;
	logic [DSZ-1:0] dat;
	logic [RSZ-1:0] red;

	// Idle -> loaded -> requesting -> back to idle on ack
	always_ff @(posedge i_clk) begin
		if (reset) begin
			busy <= 1'b0;
			req <= 1'b0;
			nxt_dst <= MIN_A;
			dat_cnt <= '0;
			sent_cnt <= '0;
			last_dst <= '0;
		end else if (!busy) begin
			if (enable) begin
				busy <= 1'b1;
				nxt_dst <= (nxt_dst >= MAX_A) ? MIN_A : nxt_dst + 1'b1;
				dat_cnt <= dat_cnt + 1'b1;
			end
		end else if (!req && !ch.ack) begin
			// Wait for the partner to finish the previous handshake
			req <= 1'b1;
		end else if (req && ch.ack) begin
			req <= 1'b0;
			busy <= 1'b0;
			sent_cnt <= sent_cnt + 1'b1;
			last_dst <= dst;
		end
	end

	// Packet fields
	always_ff @(posedge i_clk) begin
		if (!busy && enable) begin
			dst <= nxt_dst;
			dat <= dat_cnt;
			red <= calc_redun(DBG_SRC_ADDR, nxt_dst, dat_cnt);
		end
	end

	assign ch.req = req;
	assign ch.src = DBG_SRC_ADDR;
	assign ch.dst = dst;
	assign ch.dat = dat;
	assign ch.red = red;

endmodule

//--- source/pakin_fifo.sv
`timescale 1ns/10ps

module pakin_fifo #(
	parameter int DEPTH = 4
) (
	input  logic         i_clk,
	input  logic         reset,
	pak_chnl_if.receiver in_ch,
	pak_chnl_if.sender   out_ch
);
	import pakout_pkg::*;

	localparam int AW = $clog2(DEPTH);

	logic [ASZ-1:0] mem_src [DEPTH];
	logic [ASZ-1:0] mem_dst [DEPTH];
	logic [DSZ-1:0] mem_dat [DEPTH];
	logic [RSZ-1:0] mem_red [DEPTH];

	// Extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	logic full;
	logic empty;
	logic wr_en;
	logic rd_en;
	logic in_ack;
	logic out_req;

	logic [ASZ-1:0] out_src;
	logic [ASZ-1:0] out_dst;
	logic [DSZ-1:0] out_dat;
	logic [RSZ-1:0] out_red;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Take a new packet only with free space, otherwise ack is held back
	assign wr_en = in_ch.req && !in_ack && !full;
	// Offer the oldest packet once the last handshake has closed
	assign rd_en = !out_req && !out_ch.ack && !empty;

	always_ff @(posedge i_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			in_ack <= 1'b0;
			out_req <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
				in_ack <= 1'b1;
			end else if (in_ack && !in_ch.req) begin
				in_ack <= 1'b0;
			end

			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
				out_req <= 1'b1;
			end else if (out_req && out_ch.ack) begin
				out_req <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (wr_en) begin
			mem_src[wr_ptr[AW-1:0]] <= in_ch.src;
			mem_dst[wr_ptr[AW-1:0]] <= in_ch.dst;
			mem_dat[wr_ptr[AW-1:0]] <= in_ch.dat;
			mem_red[wr_ptr[AW-1:0]] <= in_ch.red;
		end
		if (rd_en) begin
			out_src <= mem_src[rd_ptr[AW-1:0]];
			out_dst <= mem_dst[rd_ptr[AW-1:0]];
			out_dat <= mem_dat[rd_ptr[AW-1:0]];
			out_red <= mem_red[rd_ptr[AW-1:0]];
		end
	end

	assign in_ch.ack = in_ack;
	assign out_ch.req = out_req;
	assign out_ch.src = out_src;
	assign out_ch.dst = out_dst;
	assign out_ch.dat = out_dat;
	assign out_ch.red = out_red;

endmodule

//--- source/pakin_chk.sv
`timescale 1ns/10ps

module pakin_chk (
	input  logic                       i_clk,
	input  logic                       reset,
	pak_chnl_if.receiver               ch,
	output logic                       err_src,
	output logic                       err_seq,
	output logic                       err_red,
	output logic                       got_pak,
	output logic [pakout_pkg::ASZ-1:0] info_0,
	output logic [pakout_pkg::DSZ-1:0] info_1
);
	import pakout_pkg::*;

	logic           ack;
	logic           take;
	logic           have_base;
	logic [DSZ-1:0] prev_dat;
	logic [DSZ-1:0] exp_dat;
	logic [RSZ-1:0] exp_red;

	assign take = ch.req && !ack;
	assign exp_dat = prev_dat + 1'b1;
	assign exp_red = calc_redun(ch.src, ch.dst, ch.dat);

	// Flags are sticky until reset
	always_ff @(posedge i_clk) begin
		if (reset) begin
			ack <= 1'b0;
			have_base <= 1'b0;
			err_src <= 1'b0;
			err_seq <= 1'b0;
			err_red <= 1'b0;
			got_pak <= 1'b0;
			info_0 <= '0;
			info_1 <= '0;
		end else if (take) begin
			ack <= 1'b1;
			got_pak <= 1'b1;
			have_base <= 1'b1;
			if (ch.src != DBG_SRC_ADDR) begin
				err_src <= 1'b1;
				info_0 <= ch.src;
			end
			// First packet after reset only sets the baseline
			if (have_base && (ch.dat != exp_dat)) begin
				err_seq <= 1'b1;
				info_1 <= ch.dat;
			end
			if (ch.red != exp_red) begin
				err_red <= 1'b1;
			end
		end else if (ack && !ch.req) begin
			ack <= 1'b0;
		end
	end

	// Every packet becomes the next baseline whether good or not
	always_ff @(posedge i_clk) begin
		if (take) begin
			prev_dat <= ch.dat;
		end
	end

	assign ch.ack = ack;

endmodule

//--- source/dbg_sel.sv
`timescale 1ns/10ps

module dbg_sel #(
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 4
) (
	input  logic                       i_clk,
	input  logic                       reset,
	input  logic [3:0]                 dbg_case,
	input  logic [3:0]                 sent_cnt,
	input  logic [pakout_pkg::ASZ-1:0] last_dst,
	input  logic                       err_src,
	input  logic                       err_seq,
	input  logic                       err_red,
	input  logic                       got_pak,
	input  logic [pakout_pkg::ASZ-1:0] info_0,
	input  logic [pakout_pkg::DSZ-1:0] info_1,
	output logic [3:0]                 dbg_leds,
	output logic [3:0]                 dbg_disp0,
	output logic [3:0]                 dbg_disp1
);
	import pakout_pkg::*;

	localparam logic [ASZ-1:0] MAX_A = ASZ'(MAX_ADDR);

	// Destination window must not be empty
	if (MIN_ADDR > MAX_ADDR) begin : g_bad_window
		$error("dbg_sel: MIN_ADDR above MAX_ADDR");
	end

	logic [3:0] src_leds;
	logic [3:0] src_disp0;
	logic [3:0] src_disp1;
	logic [3:0] snk_leds;
	logic [3:0] snk_disp0;
	logic [3:0] snk_disp1;

	// Source status where disp1 marks the end of the window
	assign src_leds = sent_cnt;
	assign src_disp0 = last_dst[3:0];
	assign src_disp1 = {3'b000, last_dst == MAX_A};

	// Sink status
	assign snk_leds = {err_src, err_seq, err_red, got_pak};
	assign snk_disp0 = info_0[3:0];
	assign snk_disp1 = info_1[3:0];

	always_ff @(posedge i_clk) begin
		if (reset) begin
			dbg_leds <= '0;
			dbg_disp0 <= '0;
			dbg_disp1 <= '0;
		end else if (dbg_case < DBG_MAX_SRC_CASE) begin
			dbg_leds <= src_leds;
			dbg_disp0 <= src_disp0;
			dbg_disp1 <= src_disp1;
		end else begin
			dbg_leds <= snk_leds;
			dbg_disp0 <= snk_disp0;
			dbg_disp1 <= snk_disp1;
		end
	end

endmodule

//--- source/pakout_top.sv
`timescale 1ns/10ps

module pakout_top #(
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 4,
	parameter int DEPTH = 4
) (
	input  logic                       i_clk,
	input  logic                       reset,
	input  logic                       enable,

	// Output channel
	output logic                       o0_req,
	output logic [pakout_pkg::ASZ-1:0] o0_src,
	output logic [pakout_pkg::ASZ-1:0] o0_dst,
	output logic [pakout_pkg::DSZ-1:0] o0_dat,
	output logic [pakout_pkg::RSZ-1:0] o0_red,
	input  logic                       o0_ack,

	// Input channel
	input  logic                       i0_req,
	input  logic [pakout_pkg::ASZ-1:0] i0_src,
	input  logic [pakout_pkg::ASZ-1:0] i0_dst,
	input  logic [pakout_pkg::DSZ-1:0] i0_dat,
	input  logic [pakout_pkg::RSZ-1:0] i0_red,
	output logic                       i0_ack,

	input  logic [3:0]                 dbg_case,
	output logic [3:0]                 dbg_leds,
	output logic [3:0]                 dbg_disp0,
	output logic [3:0]                 dbg_disp1
);
	import pakout_pkg::*;

	pak_chnl_if out_ch ();
	pak_chnl_if in_ch ();
	pak_chnl_if buf_ch ();

	logic [3:0]     sent_cnt;
	logic [ASZ-1:0] last_dst;
	logic           err_src;
	logic           err_seq;
	logic           err_red;
	logic           got_pak;
	logic [ASZ-1:0] info_0;
	logic [DSZ-1:0] info_1;

	assign o0_req = out_ch.req;
	assign o0_src = out_ch.src;
	assign o0_dst = out_ch.dst;
	assign o0_dat = out_ch.dat;
	assign o0_red = out_ch.red;
	assign out_ch.ack = o0_ack;

	assign in_ch.req = i0_req;
	assign in_ch.src = i0_src;
	assign in_ch.dst = i0_dst;
	assign in_ch.dat = i0_dat;
	assign in_ch.red = i0_red;
	assign i0_ack = in_ch.ack;

	pakout_src #(
		.MIN_ADDR(MIN_ADDR),
		.MAX_ADDR(MAX_ADDR)
	) u_src (
		.i_clk(i_clk),
		.reset(reset),
		.enable(enable),
		.ch(out_ch.sender),
		.sent_cnt(sent_cnt),
		.last_dst(last_dst)
	);

	pakin_fifo #(
		.DEPTH(DEPTH)
	) u_fifo (
		.i_clk(i_clk),
		.reset(reset),
		.in_ch(in_ch.receiver),
		.out_ch(buf_ch.sender)
	);

	pakin_chk u_chk (
		.i_clk(i_clk),
		.reset(reset),
		.ch(buf_ch.receiver),
		.err_src(err_src),
		.err_seq(err_seq),
		.err_red(err_red),
		.got_pak(got_pak),
		.info_0(info_0),
		.info_1(info_1)
	);

	dbg_sel #(
		.MIN_ADDR(MIN_ADDR),
		.MAX_ADDR(MAX_ADDR)
	) u_dbg (
		.i_clk(i_clk),
		.reset(reset),
		.dbg_case(dbg_case),
		.sent_cnt(sent_cnt),
		.last_dst(last_dst),
		.err_src(err_src),
		.err_seq(err_seq),
		.err_red(err_red),
		.got_pak(got_pak),
		.info_0(info_0),
		.info_1(info_1),
		.dbg_leds(dbg_leds),
		.dbg_disp0(dbg_disp0),
		.dbg_disp1(dbg_disp1)
	);

endmodule

//--- dv/pakout_sva.sv
`timescale 1ns/10ps

module pakout_sva (
	input logic                       i_clk,
	input logic                       reset,
	input logic                       full,
	input logic                       rd_en,
	input logic                       in_ack,
	input logic                       out_req,
	input logic                       out_ack,
	input logic [pakout_pkg::ASZ-1:0] out_src,
	input logic [pakout_pkg::ASZ-1:0] out_dst,
	input logic [pakout_pkg::DSZ-1:0] out_dat,
	input logic [pakout_pkg::RSZ-1:0] out_red
);

	// Buffered request holds until the checker answers
	a_req_hold: assert property (@(posedge i_clk) disable iff (reset)
		out_req && !out_ack |=> out_req)
		else $error("buffer req dropped before ack");

	// Offered packet does not change under a raised req
	a_fields_stable: assert property (@(posedge i_clk) disable iff (reset)
		out_req |=> !out_req || $stable({out_src, out_dst, out_dat, out_red}))
		else $error("buffer fields changed while req was high");

	a_no_ack_full: assert property (@(posedge i_clk) disable iff (reset)
		full && !rd_en |=> !$rose(in_ack))
		else $error("input ack raised with a full buffer");

endmodule

bind pakin_fifo pakout_sva u_sva (
	.i_clk(i_clk),
	.reset(reset),
	.full(full),
	.rd_en(rd_en),
	.in_ack(in_ack),
	.out_req(out_req),
	.out_ack(out_ch.ack),
	.out_src(out_src),
	.out_dst(out_dst),
	.out_dat(out_dat),
	.out_red(out_red)
);

//--- dv/pakout_tb.sv
`timescale 1ns/10ps

module pakout_tb;
	import pakout_pkg::*;

	localparam int MIN_ADDR = 1;
	localparam int MAX_ADDR = 4;
	localparam int DEPTH = 4;
	localparam int WIN = MAX_ADDR - MIN_ADDR + 1;
	localparam int MAX_CYCLES = 4000;

	logic           i_clk = 1'b0;
	logic           reset = 1'b1;
	logic           enable = 1'b0;
	logic           o0_req;
	logic [ASZ-1:0] o0_src;
	logic [ASZ-1:0] o0_dst;
	logic [DSZ-1:0] o0_dat;
	logic [RSZ-1:0] o0_red;
	logic           o0_ack = 1'b0;
	logic           i0_req = 1'b0;
	logic [ASZ-1:0] i0_src = '0;
	logic [ASZ-1:0] i0_dst = '0;
	logic [DSZ-1:0] i0_dat = '0;
	logic [RSZ-1:0] i0_red = '0;
	logic           i0_ack;
	logic [3:0]     dbg_case = 4'd0;
	logic [3:0]     dbg_leds;
	logic [3:0]     dbg_disp0;
	logic [3:0]     dbg_disp1;

	logic [31:0] lfsr = 32'h41cbf695;
	int          cycles = 0;
	int          out_idx = 0;
	int          mism_errs = 0;
	int          other_errs = 0;
	logic        quiet = 1'b1;
	logic        ack_armed = 1'b0;
	logic [31:0] ack_delay = '0;
	string       test_name = "startup";

	always #2 i_clk = ~i_clk;

	pakout_top #(
		.MIN_ADDR(MIN_ADDR),
		.MAX_ADDR(MAX_ADDR),
		.DEPTH(DEPTH)
	) dut (
		.i_clk(i_clk),
		.reset(reset),
		.enable(enable),
		.o0_req(o0_req),
		.o0_src(o0_src),
		.o0_dst(o0_dst),
		.o0_dat(o0_dat),
		.o0_red(o0_red),
		.o0_ack(o0_ack),
		.i0_req(i0_req),
		.i0_src(i0_src),
		.i0_dst(i0_dst),
		.i0_dat(i0_dat),
		.i0_red(i0_red),
		.i0_ack(i0_ack),
		.dbg_case(dbg_case),
		.dbg_leds(dbg_leds),
		.dbg_disp0(dbg_disp0),
		.dbg_disp1(dbg_disp1)
	);

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// Bit i of the fields lands in code bit i mod RSZ
	function automatic logic [RSZ-1:0] ref_red(logic [ASZ-1:0] s, logic [ASZ-1:0] d,
			logic [DSZ-1:0] v);
		logic [2*ASZ+DSZ-1:0] bits;
		logic [RSZ-1:0] r;
		bits = {s, d, v};
		r = '0;
		for (int i = 0; i < 2 * ASZ + DSZ; i++) begin
			r[i % RSZ] = r[i % RSZ] ^ bits[i];
		end
		return r;
	endfunction

	// Expected output packet n as {src, dst, dat, red}
	function automatic logic [2*ASZ+DSZ+RSZ-1:0] ref_pak(int n);
		logic [ASZ-1:0] d;
		logic [DSZ-1:0] v;
		d = ASZ'(MIN_ADDR + n % WIN);
		v = DSZ'(n);
		return {DBG_SRC_ADDR, d, v, ref_red(DBG_SRC_ADDR, d, v)};
	endfunction

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			mism_errs++;
			$display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic apply_reset();
		@(negedge i_clk);
		reset = 1'b1;
		enable = 1'b0;
		i0_req = 1'b0;
		repeat (5) @(negedge i_clk);
		reset = 1'b0;
	endtask

	// Four-phase send on i0 that starts and ends on a falling edge
	task automatic send_pak(input logic [ASZ-1:0] s, input logic [ASZ-1:0] d,
			input logic [DSZ-1:0] v, input logic [RSZ-1:0] r);
		i0_src = s;
		i0_dst = d;
		i0_dat = v;
		i0_red = r;
		i0_req = 1'b1;
		@(negedge i_clk);
		while (!i0_ack) @(negedge i_clk);
		i0_req = 1'b0;
		@(negedge i_clk);
		while (i0_ack) @(negedge i_clk);
	endtask

	task automatic send_good(input logic [ASZ-1:0] d, input logic [DSZ-1:0] v);
		send_pak(DBG_SRC_ADDR, d, v, ref_red(DBG_SRC_ADDR, d, v));
	endtask

	// Wait for an empty buffer and a closed checker handshake plus one registered cycle
	task automatic wait_drain();
		while (!(dut.u_fifo.empty && !dut.buf_ch.req && !dut.buf_ch.ack)) @(negedge i_clk);
		repeat (2) @(negedge i_clk);
	endtask

	// Receiver model for o0 with 0 to 3 cycles of ack delay
	always @(negedge i_clk) begin
		if (reset) begin
			o0_ack = 1'b0;
			ack_armed = 1'b0;
		end else if (o0_ack) begin
			if (!o0_req)
				o0_ack = 1'b0;
		end else if (o0_req) begin
			if (!ack_armed) begin
				take_bits(2, ack_delay);
				ack_armed = 1'b1;
			end
			if (ack_delay == 0) begin
				o0_ack = 1'b1;
				ack_armed = 1'b0;
			end else begin
				ack_delay = ack_delay - 1;
			end
		end
	end

	// Compare each accepted o0 packet
	always @(posedge i_clk) begin
		if (reset) begin
			out_idx = 0;
		end else if (o0_req) begin
			if (quiet) begin
				other_errs++;
				$display("%s: o0_req raised while enable was low", test_name);
			end
			if (o0_ack) begin
				if (ref_pak(out_idx) !== {o0_src, o0_dst, o0_dat, o0_red}) begin
					mism_errs++;
					$display("FAIL %s packet %0d: expected %0h, actual %0h", test_name,
						out_idx, ref_pak(out_idx), {o0_src, o0_dst, o0_dat, o0_red});
				end
				out_idx++;
			end
		end
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles, stuck in %s", cycles, test_name);
			$display("errors: %0d mismatches, %0d other", mism_errs, other_errs + 1);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		logic [31:0]                r;
		logic [DSZ-1:0]             base;
		logic [2*ASZ+DSZ+RSZ-1:0]   exp_w;
		logic [ASZ-1:0]             last_d;
		int                         k;

		test_name = "output_stream";
		apply_reset();
		repeat (16) @(negedge i_clk);
		quiet = 1'b0;
		enable = 1'b1;
		while (out_idx < 20) @(negedge i_clk);
		enable = 1'b0;
		quiet = 1'b1;

		test_name = "input_burst";
		apply_reset();
		dbg_case = 4'd8;
		take_bits(8, r);
		for (int i = 0; i < 30; i++) begin
			send_good(ASZ'(MIN_ADDR + i % WIN), r[7:0] + DSZ'(i));
		end
		wait_drain();
		check_eq("leds", 32'(4'b0001), 32'(dbg_leds));

		test_name = "bad_source";
		apply_reset();
		take_bits(8, r);
		send_pak(6'd9, ASZ'(MIN_ADDR), r[7:0], ref_red(6'd9, ASZ'(MIN_ADDR), r[7:0]));
		wait_drain();
		check_eq("leds", 32'(4'b1001), 32'(dbg_leds));
		check_eq("disp0", 32'(4'd9), 32'(dbg_disp0));

		test_name = "bad_redun";
		apply_reset();
		take_bits(8, r);
		base = r[7:0];
		send_good(ASZ'(MIN_ADDR), base);
		send_pak(DBG_SRC_ADDR, ASZ'(MAX_ADDR), base + 8'd1,
			~ref_red(DBG_SRC_ADDR, ASZ'(MAX_ADDR), base + 8'd1));
		wait_drain();
		check_eq("leds", 32'(4'b0011), 32'(dbg_leds));

		test_name = "seq_break";
		apply_reset();
		take_bits(8, r);
		base = r[7:0];
		take_bits(8, r);
		if (r[7:0] == base + 8'd1)
			r[7:0] = r[7:0] + 8'd2;
		send_good(ASZ'(MIN_ADDR), base);
		send_good(ASZ'(MIN_ADDR), r[7:0]);
		wait_drain();
		check_eq("leds", 32'(4'b0101), 32'(dbg_leds));
		check_eq("disp1", 32'(r[3:0]), 32'(dbg_disp1));

		test_name = "source_status";
		apply_reset();
		dbg_case = 4'd0;
		take_bits(3, r);
		k = 17 + int'(r[2:0]);
		quiet = 1'b0;
		enable = 1'b1;
		while (out_idx < k) @(negedge i_clk);
		enable = 1'b0;
		quiet = 1'b1;
		repeat (2) @(negedge i_clk);
		exp_w = ref_pak(k - 1);
		last_d = exp_w[RSZ+DSZ +: ASZ];
		check_eq("leds", 32'(k % 16), 32'(dbg_leds));
		check_eq("disp0", 32'(last_d[3:0]), 32'(dbg_disp0));
		check_eq("disp1", 32'(last_d == ASZ'(MAX_ADDR)), 32'(dbg_disp1));
		repeat (8) @(negedge i_clk);

		$display("errors: %0d mismatches, %0d other", mism_errs, other_errs);
		if (mism_errs == 0 && other_errs == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- flist.f
source/pakout_pkg.sv
source/pak_chnl_if.sv
source/pakout_src.sv
source/pakin_fifo.sv
source/pakin_chk.sv
source/dbg_sel.sv
source/pakout_top.sv
dv/pakout_sva.sv
dv/pakout_tb.sv

//--- run.sh
#!/bin/bash
# Build with Verilator, run, then search the log for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log build.log &&
verilator --binary --assert --timing --top-module pakout_tb -f flist.f -o pakout_sim \
	> build.log 2>&1 &&
./obj_dir/pakout_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "test passed" sim.log && echo "simulation PASS" ||
{ echo "simulation FAIL, see sim.log"; exit 1; }
